/* project.f */
hdl/ex_pkg.sv
hdl/ex_stage_reg.sv
hdl/ex_decode.sv
hdl/ex_alu.sv
hdl/ex_next_pc.sv
hdl/ex_csr_write.sv
hdl/ex_stage.sv
verif/ex_checker.sv
verif/ex_stage_asserts.sv
verif/ex_stage_tb.sv

/* Bender.yml */
package:
  name: ex_stage

sources:
  - files:
      - hdl/ex_pkg.sv
      - hdl/ex_stage_reg.sv
      - hdl/ex_decode.sv
      - hdl/ex_alu.sv
      - hdl/ex_next_pc.sv
      - hdl/ex_csr_write.sv
      - hdl/ex_stage.sv
  - target: test
    files:
      - verif/ex_checker.sv
      - verif/ex_stage_asserts.sv
      - verif/ex_stage_tb.sv

/* verif/ex_stage_tb.sv */
`timescale 1ns/1ps

module ex_stage_tb;
    import ex_pkg::*;

    localparam int N_TESTS    = 2000;
    localparam int CLK_PERIOD = 4;
    // number of ex_op_t values, nop included
    localparam int N_OPS      = 35;

    logic              clk;
    logic              rst;
    logic              id_valid;
    logic [XLEN-1:0]   id_pc;
    logic [INST_W-1:0] id_inst;
    ex_op_t            id_op;
    logic [XLEN-1:0]   id_src_a;
    logic [XLEN-1:0]   id_src_b;
    logic [XLEN-1:0]   id_imm;
    logic              mem_valid;
    logic [XLEN-1:0]   mem_pc;
    logic [INST_W-1:0] mem_inst;
    ex_op_t            mem_op;
    logic [XLEN-1:0]   mem_alu_result;
    logic [XLEN-1:0]   mem_src_b;
    logic [XLEN-1:0]   dnpc;
    logic              pc_update;
    logic              csr_mtvec_wen;
    logic              csr_mepc_wen;
    logic              csr_mcause_wen;
    logic              csr_mstatus_wen;
    logic [XLEN-1:0]   csr_mtvec_wdata;
    logic [XLEN-1:0]   csr_mepc_wdata;
    logic [XLEN-1:0]   csr_mcause_wdata;
    logic [XLEN-1:0]   csr_mstatus_wdata;
    int                err_count;
    int                check_count;
    int                assert_fails;
    logic [31:0]       lfsr_state;

    ex_stage i_dut (.*);

    ex_checker i_checker (.*);

    // failures of the bound assertions
    assign assert_fails = i_dut.i_asserts.fail_count;

    // x^32 + x^22 + x^2 + x + 1, one step per bit taken
    function automatic logic [63:0] draw_bits(input int n);
        logic [63:0] val;
        logic        fb;
        val = '0;
        for (int i = 0; i < n; i++) begin
            fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
            lfsr_state = {lfsr_state[30:0], fb};
            val = {val[62:0], fb};
        end
        return val;
    endfunction

    // small signed value, -16..15
    function automatic logic [63:0] draw_small();
        logic [4:0] s;
        s = draw_bits(5);
        return {{59{s[4]}}, s};
    endfunction

    task automatic drive_random_item();
        logic [1:0]  opnd_mode;
        logic [2:0]  csr_pick;
        logic [11:0] csr_field;
        logic [19:0] inst_low;
        logic [61:0] pc_word;
        logic [11:0] imm12;
        logic [63:0] a;
        logic [63:0] b;
        int          op_idx;
        // valid about 7 in 8
        id_valid <= (draw_bits(3) != 0);
        op_idx = int'(draw_bits(6)) % N_OPS;
        id_op <= ex_op_t'(op_idx);
        pc_word = draw_bits(62);
        id_pc <= {pc_word, 2'b00};
        // equal, small or wide operands
        opnd_mode = draw_bits(2);
        case (opnd_mode)
            2'd0: begin
                a = draw_bits(64);
                b = a;
            end
            2'd1: begin
                a = draw_small();
                b = draw_small();
            end
            default: begin
                a = draw_bits(64);
                b = draw_bits(64);
            end
        endcase
        id_src_a <= a;
        id_src_b <= b;
        // mostly i-type sized immediates
        if (draw_bits(1) != 0) begin
            imm12 = draw_bits(12);
            id_imm <= {{52{imm12[11]}}, imm12};
        end else begin
            id_imm <= draw_bits(64);
        end
        // csr field, one of four or a likely miss
        csr_pick = draw_bits(3);
        case (csr_pick)
            3'd0:    csr_field = CSR_MSTATUS;
            3'd1:    csr_field = CSR_MTVEC;
            3'd2:    csr_field = CSR_MEPC;
            3'd3:    csr_field = CSR_MCAUSE;
            default: csr_field = draw_bits(12);
        endcase
        inst_low = draw_bits(20);
        id_inst <= {csr_field, inst_low};
    endtask

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // hard stop a little past the expected run length
    initial begin
        #((N_TESTS + 20) * CLK_PERIOD);
        $display("error: watchdog timeout, the stimulus did not finish in time");
        $display("Test FAILED");
        $finish;
    end

    initial begin
        lfsr_state = 32'h276d_de2d;
        rst      = 1'b1;
        id_valid = 1'b0;
        id_pc    = '0;
        id_inst  = '0;
        id_op    = OP_NOP;
        id_src_a = '0;
        id_src_b = '0;
        id_imm   = '0;
        repeat (4) @(posedge clk);
        rst <= 1'b0;
        drive_random_item();
        for (int n = 1; n < N_TESTS; n++) begin
            @(posedge clk);
            drive_random_item();
        end
        @(posedge clk);
        id_valid <= 1'b0;
        // let the last items pass the checker
        repeat (3) @(posedge clk);
        $display("checks: %0d, errors: %0d, assertion failures: %0d",
                 check_count, err_count, assert_fails);
        if (err_count == 0 && assert_fails == 0 && check_count > 0)
            $display("Test OK");
        else
            $display("Test FAILED");
        $finish;
    end

endmodule

/* verif/ex_stage_asserts.sv */
`timescale 1ns/1ps

module ex_stage_asserts (
    input logic           clk,
    input logic           rst,
    input logic           mem_valid,
    input ex_pkg::ex_op_t mem_op,
    input logic           pc_update,
    input logic           csr_mtvec_wen,
    input logic           csr_mepc_wen,
    input logic           csr_mcause_wen,
    input logic           csr_mstatus_wen
);
    import ex_pkg::*;

    logic any_wen;
    // failed assertion count, read by the testbench
    int   fail_count = 0;

    assign any_wen = csr_mtvec_wen | csr_mepc_wen | csr_mcause_wen | csr_mstatus_wen;

    // redirect only from a live slot
    a_redirect_valid: assert property (@(posedge clk) disable iff (rst)
        pc_update |-> mem_valid)
        else begin
            $error("pc_update high while mem_valid is low");
            fail_count++;
        end

    // csr writes only from a live slot
    a_wen_valid: assert property (@(posedge clk) disable iff (rst)
        any_wen |-> mem_valid)
        else begin
            $error("csr write enable high while mem_valid is low");
            fail_count++;
        end

    // mtvec and mepc together only on trap entry
    a_wen_exclusive: assert property (@(posedge clk) disable iff (rst)
        (mem_op != OP_ECALL) |-> !(csr_mtvec_wen && csr_mepc_wen))
        else begin
            $error("mtvec and mepc written together outside ecall");
            fail_count++;
        end

    // quiet right after reset
    a_reset_quiet: assert property (@(posedge clk)
        rst |=> !(mem_valid || pc_update || any_wen))
        else begin
            $error("control output high in the cycle after reset");
            fail_count++;
        end

endmodule

bind ex_stage ex_stage_asserts i_asserts (
    .clk             (clk),
    .rst             (rst),
    .mem_valid       (mem_valid),
    .mem_op          (mem_op),
    .pc_update       (pc_update),
    .csr_mtvec_wen   (csr_mtvec_wen),
    .csr_mepc_wen    (csr_mepc_wen),
    .csr_mcause_wen  (csr_mcause_wen),
    .csr_mstatus_wen (csr_mstatus_wen)
);

/* verif/ex_checker.sv */
`timescale 1ns/1ps

module ex_checker (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      id_valid,
    input  logic [ex_pkg::XLEN-1:0]   id_pc,
    input  logic [ex_pkg::INST_W-1:0] id_inst,
    input  ex_pkg::ex_op_t            id_op,
    input  logic [ex_pkg::XLEN-1:0]   id_src_a,
    input  logic [ex_pkg::XLEN-1:0]   id_src_b,
    input  logic [ex_pkg::XLEN-1:0]   id_imm,
    input  logic                      mem_valid,
    input  logic [ex_pkg::XLEN-1:0]   mem_pc,
    input  logic [ex_pkg::INST_W-1:0] mem_inst,
    input  ex_pkg::ex_op_t            mem_op,
    input  logic [ex_pkg::XLEN-1:0]   mem_alu_result,
    input  logic [ex_pkg::XLEN-1:0]   mem_src_b,
    input  logic [ex_pkg::XLEN-1:0]   dnpc,
    input  logic                      pc_update,
    input  logic                      csr_mtvec_wen,
    input  logic                      csr_mepc_wen,
    input  logic                      csr_mcause_wen,
    input  logic                      csr_mstatus_wen,
    input  logic [ex_pkg::XLEN-1:0]   csr_mtvec_wdata,
    input  logic [ex_pkg::XLEN-1:0]   csr_mepc_wdata,
    input  logic [ex_pkg::XLEN-1:0]   csr_mcause_wdata,
    input  logic [ex_pkg::XLEN-1:0]   csr_mstatus_wdata,
    output int                        err_count,
    output int                        check_count
);
    import ex_pkg::*;

    // one-deep copy of what the dut sampled on the last edge
    logic              cap_ready = 1'b0;
    logic              cap_valid;
    logic [XLEN-1:0]   cap_pc;
    logic [INST_W-1:0] cap_inst;
    ex_op_t            cap_op;
    logic [XLEN-1:0]   cap_src_a;
    logic [XLEN-1:0]   cap_src_b;
    logic [XLEN-1:0]   cap_imm;

    initial begin
        err_count   = 0;
        check_count = 0;
    end

    function automatic logic [63:0] sext_word(input logic [31:0] w);
        return {{32{w[31]}}, w};
    endfunction

    // rv64 result per op, straight from the isa rules
    function automatic logic [63:0] model_alu(input ex_op_t op, input logic [63:0] a,
                                              input logic [63:0] b, input logic [63:0] imm,
                                              input logic [63:0] pc, input logic [31:0] inst);
        logic [5:0] sh;
        sh = inst[25:20];
        case (op)
            OP_ADD:   return a + b;
            OP_SUB:   return a - b;
            OP_SLL:   return a << b[5:0];
            OP_SRL:   return a >> b[5:0];
            OP_SRA:   return $signed(a) >>> b[5:0];
            OP_AND:   return a & b;
            OP_OR:    return a | b;
            OP_XOR:   return a ^ b;
            OP_SLT:   return ($signed(a) < $signed(b)) ? 64'd1 : 64'd0;
            OP_SLTU:  return (a < b) ? 64'd1 : 64'd0;
            OP_ADDI:  return a + imm;
            OP_SLLI:  return a << sh;
            OP_SRLI:  return a >> sh;
            OP_SRAI:  return $signed(a) >>> sh;
            OP_LUI:   return imm;
            // jal, auipc and branch targets
            OP_AUIPC, OP_JAL, OP_BEQ, OP_BNE, OP_BLT, OP_BGE, OP_BLTU, OP_BGEU:
                return pc + imm;
            OP_JALR:  return a + imm;
            OP_ADDW:  return sext_word(a[31:0] + b[31:0]);
            OP_SUBW:  return sext_word(a[31:0] - b[31:0]);
            OP_ADDIW: return sext_word(a[31:0] + imm[31:0]);
            OP_SLLW:  return sext_word(a[31:0] << b[4:0]);
            OP_SRLW:  return sext_word(a[31:0] >> b[4:0]);
            OP_SRAW:  return sext_word($signed(a[31:0]) >>> b[4:0]);
            OP_CSRRS: return a | b;
            default:  return '0;
        endcase
    endfunction

    function automatic logic model_taken(input ex_op_t op, input logic [63:0] a,
                                         input logic [63:0] b);
        case (op)
            OP_BEQ:  return a == b;
            OP_BNE:  return a != b;
            OP_BLT:  return $signed(a) < $signed(b);
            OP_BGE:  return $signed(a) >= $signed(b);
            OP_BLTU: return a < b;
            OP_BGEU: return a >= b;
            default: return 1'b0;
        endcase
    endfunction

    function automatic logic [63:0] model_dnpc(input ex_op_t op, input logic [63:0] a,
                                               input logic [63:0] b, input logic [63:0] imm,
                                               input logic [63:0] pc);
        case (op)
            OP_JAL:            return pc + imm;
            OP_JALR:           return (a + imm) & ~64'd1;
            OP_ECALL, OP_MRET: return b;
            OP_BEQ, OP_BNE, OP_BLT, OP_BGE, OP_BLTU, OP_BGEU:
                return model_taken(op, a, b) ? pc + imm : pc + 64'd4;
            default:           return pc + 64'd4;
        endcase
    endfunction

    task automatic check_value(input string name, input logic [63:0] exp,
                               input logic [63:0] act);
        check_count++;
        if (act !== exp) begin
            err_count++;
            $display("FAIL %s: expected %h, actual %h", name, exp, act);
        end
    endtask

    task automatic compare_outputs();
        ex_op_t      op;
        string       tag;
        logic [11:0] addr;
        logic        is_csr;
        logic        is_ecall;
        logic [63:0] csr_data;
        logic        exp_mtvec_wen;
        logic        exp_mepc_wen;
        logic        exp_mcause_wen;
        logic        exp_mstatus_wen;
        logic        exp_redirect;
        op = cap_valid ? cap_op : OP_NOP;
        tag = op.name();
        addr = cap_inst[31:20];
        is_csr = (op == OP_CSRRW) || (op == OP_CSRRS);
        is_ecall = (op == OP_ECALL);
        // csrrs sets bits, csrrw replaces
        csr_data = (op == OP_CSRRS) ? (cap_src_a | cap_src_b) : cap_src_a;
        exp_mtvec_wen   = is_csr && (addr == CSR_MTVEC);
        exp_mstatus_wen = is_csr && (addr == CSR_MSTATUS);
        exp_mepc_wen    = is_ecall || (is_csr && (addr == CSR_MEPC));
        exp_mcause_wen  = is_ecall || (is_csr && (addr == CSR_MCAUSE));
        exp_redirect = op inside {OP_BEQ, OP_BNE, OP_BLT, OP_BGE, OP_BLTU, OP_BGEU,
                                  OP_JAL, OP_JALR, OP_ECALL, OP_MRET};

        // plain register copies
        check_value("mem_valid", cap_valid, mem_valid);
        check_value("mem_op", op, mem_op);
        check_value("mem_pc", cap_pc, mem_pc);
        check_value("mem_inst", cap_inst, mem_inst);
        check_value("mem_src_b", cap_src_b, mem_src_b);

        // result left undefined for nop, csrrw and traps
        if (!(op inside {OP_NOP, OP_CSRRW, OP_ECALL, OP_MRET}))
            check_value($sformatf("alu_result %s", tag),
                        model_alu(op, cap_src_a, cap_src_b, cap_imm, cap_pc, cap_inst),
                        mem_alu_result);

        check_value($sformatf("dnpc %s", tag),
                    model_dnpc(op, cap_src_a, cap_src_b, cap_imm, cap_pc), dnpc);
        check_value($sformatf("pc_update %s", tag), exp_redirect, pc_update);

        // csr enables, data zero when idle
        check_value($sformatf("mtvec_wen %s", tag), exp_mtvec_wen, csr_mtvec_wen);
        check_value($sformatf("mepc_wen %s", tag), exp_mepc_wen, csr_mepc_wen);
        check_value($sformatf("mcause_wen %s", tag), exp_mcause_wen, csr_mcause_wen);
        check_value($sformatf("mstatus_wen %s", tag), exp_mstatus_wen, csr_mstatus_wen);
        check_value($sformatf("mtvec_wdata %s", tag),
                    exp_mtvec_wen ? csr_data : 64'd0, csr_mtvec_wdata);
        check_value($sformatf("mstatus_wdata %s", tag),
                    exp_mstatus_wen ? csr_data : 64'd0, csr_mstatus_wdata);
        // trap entry saves pc and cause
        check_value($sformatf("mepc_wdata %s", tag),
                    is_ecall ? cap_pc : (exp_mepc_wen ? csr_data : 64'd0), csr_mepc_wdata);
        check_value($sformatf("mcause_wdata %s", tag),
                    is_ecall ? 64'd11 : (exp_mcause_wen ? csr_data : 64'd0),
                    csr_mcause_wdata);
    endtask

    // same edge as the dut, so same input values
    always @(posedge clk) begin
        cap_ready <= 1'b1;
        cap_valid <= !rst && id_valid;
        cap_op    <= id_op;
        cap_pc    <= id_pc;
        cap_inst  <= id_inst;
        cap_src_a <= id_src_a;
        cap_src_b <= id_src_b;
        cap_imm   <= id_imm;
    end

    // outputs settled by mid-cycle
    always @(negedge clk) begin
        if (cap_ready)
            compare_outputs();
    end

endmodule

/* hdl/ex_stage.sv */
`timescale 1ns/1ps

module ex_stage (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      id_valid,
    input  logic [ex_pkg::XLEN-1:0]   id_pc,
    input  logic [ex_pkg::INST_W-1:0] id_inst,
    input  ex_pkg::ex_op_t            id_op,
    input  logic [ex_pkg::XLEN-1:0]   id_src_a,
    input  logic [ex_pkg::XLEN-1:0]   id_src_b,
    input  logic [ex_pkg::XLEN-1:0]   id_imm,
    output logic                      mem_valid,
    output logic [ex_pkg::XLEN-1:0]   mem_pc,
    output logic [ex_pkg::INST_W-1:0] mem_inst,
    output ex_pkg::ex_op_t            mem_op,
    output logic [ex_pkg::XLEN-1:0]   mem_alu_result,
    output logic [ex_pkg::XLEN-1:0]   mem_src_b,
    output logic [ex_pkg::XLEN-1:0]   dnpc,
    output logic                      pc_update,
    output logic                      csr_mtvec_wen,
    output logic                      csr_mepc_wen,
    output logic                      csr_mcause_wen,
    output logic                      csr_mstatus_wen,
    output logic [ex_pkg::XLEN-1:0]   csr_mtvec_wdata,
    output logic [ex_pkg::XLEN-1:0]   csr_mepc_wdata,
    output logic [ex_pkg::XLEN-1:0]   csr_mcause_wdata,
    output logic [ex_pkg::XLEN-1:0]   csr_mstatus_wdata
);
    import ex_pkg::*;

    // registered operands that do not leave the stage
    logic [XLEN-1:0] ex_src_a;
    logic [XLEN-1:0] ex_imm;

    // decoder controls
    alu_mode_t alu_mode;
    opa_sel_t  opa_sel;
    opb_sel_t  opb_sel;
    logic      word_op;
    logic      is_branch;
    logic      is_jump;
    logic      jump_lsb_clear;
    logic      is_trap_target;
    logic      csr_write;
    logic      csr_set;
    logic      trap_enter;

    // the only clocked block, its copies go straight out to mem
    ex_stage_reg i_stage_reg (
        .clk      (clk),
        .rst      (rst),
        .id_valid (id_valid),
        .id_pc    (id_pc),
        .id_inst  (id_inst),
        .id_op    (id_op),
        .id_src_a (id_src_a),
        .id_src_b (id_src_b),
        .id_imm   (id_imm),
        .valid    (mem_valid),
        .pc       (mem_pc),
        .inst     (mem_inst),
        .op       (mem_op),
        .src_a    (ex_src_a),
        .src_b    (mem_src_b),
        .imm      (ex_imm)
    );

    ex_decode i_decode (
        .op             (mem_op),
        .alu_mode       (alu_mode),
        .opa_sel        (opa_sel),
        .opb_sel        (opb_sel),
        .word_op        (word_op),
        .is_branch      (is_branch),
        .is_jump        (is_jump),
        .jump_lsb_clear (jump_lsb_clear),
        .is_trap_target (is_trap_target),
        .csr_write      (csr_write),
        .csr_set        (csr_set),
        .trap_enter     (trap_enter)
    );

    ex_alu i_alu (
        .alu_mode   (alu_mode),
        .opa_sel    (opa_sel),
        .opb_sel    (opb_sel),
        .word_op    (word_op),
        .pc         (mem_pc),
        .inst       (mem_inst),
        .src_a      (ex_src_a),
        .src_b      (mem_src_b),
        .imm        (ex_imm),
        .alu_result (mem_alu_result)
    );

    // branch and jump targets come out of the alu adder
    ex_next_pc i_next_pc (
        .op             (mem_op),
        .pc             (mem_pc),
        .src_a          (ex_src_a),
        .src_b          (mem_src_b),
        .alu_result     (mem_alu_result),
        .is_branch      (is_branch),
        .is_jump        (is_jump),
        .jump_lsb_clear (jump_lsb_clear),
        .is_trap_target (is_trap_target),
        .dnpc           (dnpc),
        .pc_update      (pc_update)
    );

    ex_csr_write i_csr_write (
        .inst              (mem_inst),
        .pc                (mem_pc),
        .src_a             (ex_src_a),
        .alu_result        (mem_alu_result),
        .csr_write         (csr_write),
        .csr_set           (csr_set),
        .trap_enter        (trap_enter),
        .csr_mtvec_wen     (csr_mtvec_wen),
        .csr_mepc_wen      (csr_mepc_wen),
        .csr_mcause_wen    (csr_mcause_wen),
        .csr_mstatus_wen   (csr_mstatus_wen),
        .csr_mtvec_wdata   (csr_mtvec_wdata),
        .csr_mepc_wdata    (csr_mepc_wdata),
        .csr_mcause_wdata  (csr_mcause_wdata),
        .csr_mstatus_wdata (csr_mstatus_wdata)
    );

endmodule

/* hdl/ex_csr_write.sv */
`timescale 1ns/1ps

module ex_csr_write (
    input  logic [ex_pkg::INST_W-1:0] inst,
    input  logic [ex_pkg::XLEN-1:0]   pc,
    input  logic [ex_pkg::XLEN-1:0]   src_a,
    input  logic [ex_pkg::XLEN-1:0]   alu_result,
    input  logic                      csr_write,
    input  logic                      csr_set,
    input  logic                      trap_enter,
    output logic                      csr_mtvec_wen,
    output logic                      csr_mepc_wen,
    output logic                      csr_mcause_wen,
    output logic                      csr_mstatus_wen,
    output logic [ex_pkg::XLEN-1:0]   csr_mtvec_wdata,
    output logic [ex_pkg::XLEN-1:0]   csr_mepc_wdata,
    output logic [ex_pkg::XLEN-1:0]   csr_mcause_wdata,
    output logic [ex_pkg::XLEN-1:0]   csr_mstatus_wdata
);
    import ex_pkg::*;

    logic [11:0]     csr_addr;
    logic [XLEN-1:0] csr_data;

    // csr number sits in the i-type immediate field
    assign csr_addr = inst[31:20];
    // csrrw writes rs1, csrrs writes rs1 | old value from the alu
    assign csr_data = csr_set ? alu_result : src_a;

    // address decode, ecall also hits mepc and mcause
    assign csr_mtvec_wen   = csr_write && (csr_addr == CSR_MTVEC);
    assign csr_mstatus_wen = csr_write && (csr_addr == CSR_MSTATUS);
    assign csr_mepc_wen    = trap_enter || (csr_write && (csr_addr == CSR_MEPC));
    assign csr_mcause_wen  = trap_enter || (csr_write && (csr_addr == CSR_MCAUSE));

    // data held at zero while the enable is low
    assign csr_mtvec_wdata   = csr_mtvec_wen ? csr_data : '0;
    assign csr_mstatus_wdata = csr_mstatus_wen ? csr_data : '0;
    // trap entry saves the faulting pc and the cause code
    assign csr_mepc_wdata    = trap_enter ? pc :
                               csr_mepc_wen ? csr_data : '0;
    assign csr_mcause_wdata  = trap_enter ? CAUSE_ECALL_M :
                               csr_mcause_wen ? csr_data : '0;

endmodule

/* hdl/ex_next_pc.sv */
`timescale 1ns/1ps

module ex_next_pc (
    input  ex_pkg::ex_op_t          op,
    input  logic [ex_pkg::XLEN-1:0] pc,
    input  logic [ex_pkg::XLEN-1:0] src_a,
    input  logic [ex_pkg::XLEN-1:0] src_b,
    input  logic [ex_pkg::XLEN-1:0] alu_result,
    input  logic                    is_branch,
    input  logic                    is_jump,
    input  logic                    jump_lsb_clear,
    input  logic                    is_trap_target,
    output logic [ex_pkg::XLEN-1:0] dnpc,
    output logic                    pc_update
);
    import ex_pkg::*;

    logic eq;
    logic lt;
    logic ltu;
    logic taken;

    // three raw compares, the op picks one and its sense
    assign eq  = (src_a == src_b);
    assign lt  = ($signed(src_a) < $signed(src_b));
    assign ltu = (src_a < src_b);

    always_comb begin
        case (op)
            OP_BEQ:  taken = eq;
            OP_BNE:  taken = !eq;
            OP_BLT:  taken = lt;
            OP_BGE:  taken = !lt;
            OP_BLTU: taken = ltu;
            OP_BGEU: taken = !ltu;
            default: taken = 1'b0;
        endcase
    end

    // trap target beats jump beats branch, else fall through
    always_comb begin
        if (is_trap_target)
            dnpc = src_b;
        else if (is_jump)
            dnpc = {alu_result[XLEN-1:1], alu_result[0] & !jump_lsb_clear};
        else if (is_branch && taken)
            dnpc = alu_result;
        else
            dnpc = pc + XLEN'(4);
    end

    // not-taken branches still redirect, to pc + 4
    assign pc_update = is_branch | is_jump | is_trap_target;

endmodule

/* hdl/ex_alu.sv */
`timescale 1ns/1ps

module ex_alu (
    input  ex_pkg::alu_mode_t         alu_mode,
    input  ex_pkg::opa_sel_t          opa_sel,
    input  ex_pkg::opb_sel_t          opb_sel,
    input  logic                      word_op,
    input  logic [ex_pkg::XLEN-1:0]   pc,
    input  logic [ex_pkg::INST_W-1:0] inst,
    input  logic [ex_pkg::XLEN-1:0]   src_a,
    input  logic [ex_pkg::XLEN-1:0]   src_b,
    input  logic [ex_pkg::XLEN-1:0]   imm,
    output logic [ex_pkg::XLEN-1:0]   alu_result
);
    import ex_pkg::*;

    logic [XLEN-1:0] opa_raw;
    logic [XLEN-1:0] op_a;
    logic [XLEN-1:0] op_b;
    logic [5:0]      shamt;
    logic [XLEN-1:0] raw;

    // a-side source
    always_comb begin
        case (opa_sel)
            OPA_PC:   opa_raw = pc;
            OPA_ZERO: opa_raw = '0;
            default:  opa_raw = src_a;
        endcase
    end

    // b-side source, shamt is the 6-bit rv64 field
    always_comb begin
        case (opb_sel)
            OPB_IMM:   op_b = imm;
            OPB_SHAMT: op_b = {{(XLEN-6){1'b0}}, inst[25:20]};
            default:   op_b = src_b;
        endcase
    end

    // word ops place the low half at the bottom of the 64-bit word
    // sraw needs the sign filled above it so ones shift down into bit 31
    assign op_a = !word_op ? opa_raw :
                  (alu_mode == ALU_SRA) ? {{32{opa_raw[31]}}, opa_raw[31:0]} :
                                          {32'b0, opa_raw[31:0]};

    // word shifts only look at five bits
    assign shamt = word_op ? {1'b0, op_b[4:0]} : op_b[5:0];

    always_comb begin
        case (alu_mode)
            ALU_SUB:  raw = op_a - op_b;
            ALU_SLL:  raw = op_a << shamt;
            ALU_SRL:  raw = op_a >> shamt;
            ALU_SRA:  raw = $unsigned($signed(op_a) >>> shamt);
            ALU_AND:  raw = op_a & op_b;
            ALU_OR:   raw = op_a | op_b;
            ALU_XOR:  raw = op_a ^ op_b;
            ALU_SLT:  raw = {{(XLEN-1){1'b0}}, $signed(op_a) < $signed(op_b)};
            ALU_SLTU: raw = {{(XLEN-1){1'b0}}, op_a < op_b};
            default:  raw = op_a + op_b;
        endcase
    end

    // word result: low half, sign-extended
    assign alu_result = word_op ? {{32{raw[31]}}, raw[31:0]} : raw;

endmodule

/* hdl/ex_decode.sv */
`timescale 1ns/1ps

module ex_decode (
    input  ex_pkg::ex_op_t    op,
    output ex_pkg::alu_mode_t alu_mode,
    output ex_pkg::opa_sel_t  opa_sel,
    output ex_pkg::opb_sel_t  opb_sel,
    output logic              word_op,
    output logic              is_branch,
    output logic              is_jump,
    output logic              jump_lsb_clear,
    output logic              is_trap_target,
    output logic              csr_write,
    output logic              csr_set,
    output logic              trap_enter
);
    import ex_pkg::*;

    // alu function and operand routing
    always_comb begin
        alu_mode = ALU_ADD;
        opa_sel  = OPA_SRC;
        opb_sel  = OPB_SRC;
        case (op)
            OP_SUB, OP_SUBW: alu_mode = ALU_SUB;
            OP_SLL, OP_SLLW: alu_mode = ALU_SLL;
            OP_SRL, OP_SRLW: alu_mode = ALU_SRL;
            OP_SRA, OP_SRAW: alu_mode = ALU_SRA;
            OP_AND:          alu_mode = ALU_AND;
            OP_OR:           alu_mode = ALU_OR;
            OP_XOR:          alu_mode = ALU_XOR;
            OP_SLT:          alu_mode = ALU_SLT;
            OP_SLTU:         alu_mode = ALU_SLTU;
            // csrrs ors the old csr value in src_b into src_a
            OP_CSRRS:        alu_mode = ALU_OR;
            // jalr target is src_a + imm, lsb cleared later
            OP_ADDI, OP_ADDIW, OP_JALR: opb_sel = OPB_IMM;
            // shift amount straight from inst[25:20]
            OP_SLLI: begin
                alu_mode = ALU_SLL;
                opb_sel  = OPB_SHAMT;
            end
            OP_SRLI: begin
                alu_mode = ALU_SRL;
                opb_sel  = OPB_SHAMT;
            end
            OP_SRAI: begin
                alu_mode = ALU_SRA;
                opb_sel  = OPB_SHAMT;
            end
            // lui is 0 + imm
            OP_LUI: begin
                opa_sel = OPA_ZERO;
                opb_sel = OPB_IMM;
            end
            // pc-relative: auipc result, jal and branch targets
            OP_AUIPC, OP_JAL, OP_BEQ, OP_BNE, OP_BLT, OP_BGE, OP_BLTU, OP_BGEU: begin
                opa_sel = OPA_PC;
                opb_sel = OPB_IMM;
            end
            // nop, add, addw, csrrw and traps keep src_a + src_b
            default: ;
        endcase
    end

    // 32-bit forms, result gets sign-extended in the alu
    assign word_op = op inside {OP_ADDW, OP_SUBW, OP_ADDIW, OP_SLLW, OP_SRLW, OP_SRAW};

    // redirect controls
    assign is_branch      = op inside {OP_BEQ, OP_BNE, OP_BLT, OP_BGE, OP_BLTU, OP_BGEU};
    assign is_jump        = op inside {OP_JAL, OP_JALR};
    assign jump_lsb_clear = (op == OP_JALR);
    // ecall and mret take their target from src_b
    assign is_trap_target = op inside {OP_ECALL, OP_MRET};

    // csr controls
    assign csr_write  = op inside {OP_CSRRW, OP_CSRRS};
    assign csr_set    = (op == OP_CSRRS);
    assign trap_enter = (op == OP_ECALL);

endmodule

/* hdl/ex_stage_reg.sv */
`timescale 1ns/1ps

module ex_stage_reg (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      id_valid,
    input  logic [ex_pkg::XLEN-1:0]   id_pc,
    input  logic [ex_pkg::INST_W-1:0] id_inst,
    input  ex_pkg::ex_op_t            id_op,
    input  logic [ex_pkg::XLEN-1:0]   id_src_a,
    input  logic [ex_pkg::XLEN-1:0]   id_src_b,
    input  logic [ex_pkg::XLEN-1:0]   id_imm,
    output logic                      valid,
    output logic [ex_pkg::XLEN-1:0]   pc,
    output logic [ex_pkg::INST_W-1:0] inst,
    output ex_pkg::ex_op_t            op,
    output logic [ex_pkg::XLEN-1:0]   src_a,
    output logic [ex_pkg::XLEN-1:0]   src_b,
    output logic [ex_pkg::XLEN-1:0]   imm
);
    import ex_pkg::*;

    // control half of the boundary
    // an empty slot turns into a nop so nothing downstream fires
    always_ff @(posedge clk) begin
        if (rst) begin
            valid <= 1'b0;
            op    <= OP_NOP;
        end else begin
            valid <= id_valid;
            op    <= id_valid ? id_op : OP_NOP;
        end
    end

    // payload, loaded every cycle
    always_ff @(posedge clk) begin
        pc    <= id_pc;
        inst  <= id_inst;
        src_a <= id_src_a;
        src_b <= id_src_b;
        imm   <= id_imm;
    end

endmodule

/* hdl/ex_pkg.sv */
package ex_pkg;

    // datapath and address width
    localparam int XLEN   = 64;
    // raw instruction word
    localparam int INST_W = 32;

    // execute operation, nop must stay zero
    typedef enum logic [5:0] {
        OP_NOP = 6'd0,
        OP_ADD, OP_SUB, OP_SLL, OP_SRL, OP_SRA,
        OP_AND, OP_OR, OP_XOR, OP_SLT, OP_SLTU,
        OP_ADDI, OP_SLLI, OP_SRLI, OP_SRAI,
        OP_LUI, OP_AUIPC, OP_JAL, OP_JALR,
        OP_BEQ, OP_BNE, OP_BLT, OP_BGE, OP_BLTU, OP_BGEU,
        OP_ADDW, OP_SUBW, OP_ADDIW, OP_SLLW, OP_SRLW, OP_SRAW,
        OP_CSRRW, OP_CSRRS, OP_ECALL, OP_MRET
    } ex_op_t;

    // alu function
    typedef enum logic [3:0] {
        ALU_ADD, ALU_SUB, ALU_SLL, ALU_SRL, ALU_SRA,
        ALU_AND, ALU_OR, ALU_XOR, ALU_SLT, ALU_SLTU
    } alu_mode_t;

    // alu a-side source
    typedef enum logic [1:0] {OPA_SRC, OPA_PC, OPA_ZERO} opa_sel_t;
    // alu b-side source
    typedef enum logic [1:0] {OPB_SRC, OPB_IMM, OPB_SHAMT} opb_sel_t;

    // machine csr addresses
    localparam logic [11:0] CSR_MSTATUS = 12'h300;
    localparam logic [11:0] CSR_MTVEC   = 12'h305;
    localparam logic [11:0] CSR_MEPC    = 12'h341;
    localparam logic [11:0] CSR_MCAUSE  = 12'h342;

    // environment call from m-mode
    localparam logic [XLEN-1:0] CAUSE_ECALL_M = 64'd11;

endpackage
